//--- build.f
hdl/ddr_pkg.sv
hdl/refresh_timer.sv
hdl/cmd_scheduler.sv
hdl/data_path.sv
hdl/ddr_ctrl_top.sv
testbench/sdram_model.sv
testbench/tb_ddr_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ddr_ctrl
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= run.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)

run: build
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_ddr_ctrl.sv
module tb_ddr_ctrl;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int refresh_interval = 200;
  localparam int cas_latency      = 2;
  localparam int clk_period       = 4;
  localparam int n_trans          = 64;  // upper bound on transactions below
  localparam logic [31:0] lfsr_taps = 32'hb4bc_d35c;

  logic              CLK = 1'b0;
  logic              RST;
  logic [25:0]       addr_rand;
  logic [25:0]       addr_bulk;
  logic              we_rand, req_rand, grant_rand, we_bulk, req_bulk, grant_bulk;
  logic              req_align, grant_align, read_valid, dq_oe;
  logic [3:0]        be_rand, be_bulk;
  logic [31:0]       data_w, data_r;
  ddr_pkg::ddr_cmd_e cmd;
  logic [12:0]       ddr_addr;
  logic [1:0]        ddr_bank, dm;
  logic [15:0]       dq_out, dq_in;
  int                model_errors, arsr_count, actv_count;

  int          errors = 0;
  int          cycle;
  int          t_bulk, t_rand;  // grant cycles
  logic [31:0] lfsr = 32'd22;
  logic [31:0] shadow [logic [25:0]];
  logic [31:0] exp_q [$];
  string       name_q [$];
  logic [31:0] exp_w;
  string       exp_name;

  ddr_ctrl_top #(.refresh_interval(refresh_interval), .cas_latency(cas_latency)) u_dut (.*);

  sdram_model #(.cas_latency(cas_latency)) u_model (.*, .errors(model_errors));

  always #(clk_period / 2) CLK = ~CLK;

  always @(posedge CLK) cycle <= RST ? cycle + 1 : 0;

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    int i;
    r = '0;
    for (i = 0; i < n; i++)
    begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);  // galois step
    end
    return r;
  endfunction

  function automatic logic [25:0] rand_addr();
    logic [31:0] r;
    r = take_bits(26);
    return r[25:0];
  endfunction

  // expected word after a granted access with writes merged under byte enables
  function automatic logic [31:0] ref_word(input logic we, input logic [25:0] addr,
                                           input logic [3:0] be, input logic [31:0] data);
    logic [31:0] w;
    int k;
    w = shadow.exists(addr) ? shadow[addr] : {addr, addr[25:20]} ^ 32'h5a5a_c3c3;
    if (we)
    begin
      for (k = 0; k < 4; k++)
        if (be[k])
          w[k*8 +: 8] = data[k*8 +: 8];
      shadow[addr] = w;
    end
    return w;
  endfunction

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual)
    else
    begin
      errors++;
      $display("ERROR %s: expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic access(input logic bulk, input logic we, input logic [25:0] addr,
                        input logic [3:0] be, input logic [31:0] data, input string name);
    logic granted;
    logic [31:0] w;
    @(negedge CLK);
    if (bulk)
      {req_bulk, we_bulk, addr_bulk, be_bulk} = {1'b1, we, addr, be};
    else
      {req_rand, we_rand, addr_rand, be_rand} = {1'b1, we, addr, be};
    if (we)
      data_w = data;  // held until the grant
    granted = 1'b0;
    while (!granted)
    begin
      @(negedge CLK);
      granted = bulk ? grant_bulk : grant_rand;
    end
    if (bulk)
      {req_bulk, t_bulk} = {1'b0, cycle};
    else
      {req_rand, t_rand} = {1'b0, cycle};
    check_equal(name, {17'b0, addr[13:12], addr[11:0], 1'b0}, {17'b0, ddr_bank, ddr_addr});
    w = ref_word(we, addr, be, data);
    if (!we)
    begin
      exp_q.push_back(w);
      name_q.push_back(name);
    end
  endtask

  // read data against the oldest granted read
  always @(negedge CLK)
  begin
    if (read_valid)
    begin
      assert (exp_q.size() > 0)
      else
      begin
        errors++;
        $display("read data returned with no read pending at %0t", $time);
      end
      if (exp_q.size() > 0)
      begin
        exp_w    = exp_q.pop_front();
        exp_name = name_q.pop_front();
        check_equal(exp_name, exp_w, data_r);
      end
    end
  end

  initial
  begin
    #(n_trans * 400 * clk_period);
    $display("timeout: run did not finish within %0d cycles", n_trans * 400);
    $display("Regression failed");
    $finish;
  end

  initial
  begin
    logic [25:0] addrs [10];
    logic [25:0] a;
    logic [25:0] b;
    logic [31:0] r;
    int i;
    int actv0;
    int arsr0;
    int periods;
    {RST, req_rand, we_rand, req_bulk, we_bulk, req_align} = 6'b0;
    {addr_rand, addr_bulk, be_rand, be_bulk, data_w} = '0;
    repeat (10) @(negedge CLK);
    RST = 1'b1;
    @(negedge CLK);
    check_equal("reset", {11'b0, ddr_pkg::noop, 5'b0, ddr_pkg::all_banks_addr},
                {11'b0, cmd, grant_rand, grant_bulk, grant_align, dq_oe, read_valid, ddr_addr});

    for (i = 0; i < 10; i++)
    begin
      addrs[i] = rand_addr();
      access(1'b0, 1'b1, addrs[i], 4'hf, take_bits(32), "write_read");
    end
    for (i = 0; i < 10; i++)
      access(1'b0, 1'b0, addrs[i], 4'hf, 32'h0, "write_read");

    // open the bulk row ahead, then stay on it
    a = rand_addr();
    @(negedge CLK);
    {addr_bulk, req_align} = {a, 1'b1};
    while (!grant_align)
      @(negedge CLK);
    {actv0, arsr0} = {actv_count, arsr_count};
    repeat (8) @(negedge CLK);  // align held with the page open
    req_align = 1'b0;
    for (i = 0; i < 3; i++)
    begin
      r = take_bits(12);
      b = {a[25:12], r[11:0]};
      access(1'b1, 1'b1, b, 4'hf, take_bits(32), "page");
      access(1'b1, 1'b0, b, 4'hf, 32'h0, "page");
    end
    assert (actv_count - actv0 <= arsr_count - arsr0)
    else
    begin
      errors++;
      $display("row activated again between accesses to the open row");
    end

    for (i = 0; i < 4; i++)
    begin
      b = rand_addr();
      fork
        access(1'b1, 1'b1, b, 4'hf, take_bits(32), "arbitration");
        access(1'b0, 1'b0, addrs[i], 4'hf, 32'h0, "arbitration");
      join
      assert (t_bulk < t_rand)
      else
      begin
        errors++;
        $display("random port granted before the bulk port in a shared cycle");
      end
    end

    for (i = 0; i < 8; i++)
    begin
      b = rand_addr();
      r = take_bits(4);
      access(1'b0, 1'b1, b, r[3:0], take_bits(32), "byte_mask");
      r = take_bits(4);
      access(1'b1, 1'b1, b, r[3:0], take_bits(32), "byte_mask");
      access(1'b0, 1'b0, b, 4'hf, 32'h0, "byte_mask");
    end

    while (exp_q.size() != 0)
      @(negedge CLK);
    repeat (4) @(negedge CLK);
    periods = cycle / refresh_interval;  // one strobe toggle per interval
    assert (arsr_count >= periods - 1 && arsr_count <= periods + 1)
    else
    begin
      errors++;
      $display("ERROR refresh: expected %0d actual %0d", periods, arsr_count);
    end

    $display("errors: %0d in testbench checks, %0d in the model", errors, model_errors);
    if (errors == 0 && model_errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- testbench/sdram_model.sv
module sdram_model #(
  parameter int cas_latency = 2
) (
  input  logic              CLK,
  input  logic              RST,
  input  ddr_pkg::ddr_cmd_e cmd,
  input  logic [12:0]       ddr_addr,
  input  logic [1:0]        ddr_bank,
  input  logic [15:0]       dq_out,
  input  logic              dq_oe,
  input  logic [1:0]        dm,
  output logic [15:0]       dq_in,
  output int                errors,
  output int                arsr_count,
  output int                actv_count
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0]            mem [logic [25:0]];  // word storage {row, bank, col}
  logic [15:0]            beat = 16'h0;
  logic                   page_open;
  logic                   busy;     // a command in the last cycle
  logic                   wr_hi;    // next write beat is the high half
  logic [11:0]            open_row;
  logic [1:0]             open_bank;
  logic [25:0]            wr_addr;
  logic [25:0]            word_addr;
  logic [cas_latency-1:0] rd_v;     // read command age
  logic [25:0]            rd_a [cas_latency];
  logic [31:0]            w;

  function automatic logic [31:0] word_at(input logic [25:0] a);
    return mem.exists(a) ? mem[a] : {a, a[25:20]} ^ 32'h5a5a_c3c3;  // fill for fresh words
  endfunction

  function automatic logic [15:0] half_at(input logic [25:0] a, input logic hi);
    logic [31:0] v;
    v = word_at(a);
    return hi ? v[31:16] : v[15:0];
  endfunction

  task automatic check_rule(input logic ok, input string what);
    assert (ok)
    else
    begin
      errors++;
      $display("model: %s at %0t", what, $time);
    end
  endtask

  assign dq_in = beat;

  always @(posedge CLK)
  begin
    if (!RST)
    begin
      page_open  = 1'b0;
      busy       = 1'b0;
      rd_v       = '0;
      errors     = 0;
      arsr_count = 0;
      actv_count = 0;
    end
    else
    begin
      if (dq_oe)
      begin
        w = word_at(wr_addr);
        for (int k = 0; k < 2; k++)
          if (!dm[k])
            w[(wr_hi ? 16 : 0) + k*8 +: 8] = dq_out[k*8 +: 8];  // masked bytes kept
        mem[wr_addr] = w;
        wr_hi = 1'b1;
      end
      // low beat on the bus cas_latency cycles after the command
      beat <= rd_v[cas_latency-2] ? half_at(rd_a[cas_latency-2], 1'b0) :
                                    half_at(rd_a[cas_latency-1], 1'b1);
      word_addr = {open_row, ddr_bank, ddr_addr[12:1]};
      for (int i = cas_latency - 1; i > 0; i--)
        rd_a[i] = rd_a[i-1];
      rd_a[0] = word_addr;
      rd_v = {rd_v[cas_latency-2:0], cmd == ddr_pkg::read};
      if (cmd != ddr_pkg::noop)
        check_rule(!busy, "two commands in adjacent cycles");
      busy = (cmd != ddr_pkg::noop);
      case (cmd)
        ddr_pkg::actv:
        begin
          check_rule(!page_open, "activate while a row is already open");
          page_open = 1'b1;
          open_row  = {ddr_addr[12:11], ddr_addr[9:0]};  // a10 is not a row bit
          open_bank = ddr_bank;
          actv_count++;
        end
        ddr_pkg::read, ddr_pkg::wrte:
        begin
          check_rule(page_open && ddr_bank == open_bank, "read or write to a row that is not open");
          if (cmd == ddr_pkg::wrte)
            wr_addr = word_addr;
          wr_hi = 1'b0;
        end
        ddr_pkg::prch:
          page_open = 1'b0;
        ddr_pkg::arsr:
        begin
          check_rule(!page_open, "refresh issued with a row open");
          arsr_count++;
        end
        default: ;
      endcase
    end
  end

endmodule

//--- hdl/ddr_ctrl_top.sv
module ddr_ctrl_top #(
  parameter int refresh_interval = 200,
  parameter int cas_latency      = 2
) (
  input  logic                             CLK,
  input  logic                             RST,
  // random port
  input  logic [ddr_pkg::addr_w-1:0]       addr_rand,
  input  logic                             we_rand,
  input  logic                             req_rand,
  output logic                             grant_rand,
  input  logic [3:0]                       be_rand,
  // bulk port
  input  logic [ddr_pkg::addr_w-1:0]       addr_bulk,
  input  logic                             we_bulk,
  input  logic                             req_bulk,
  output logic                             grant_bulk,
  input  logic                             req_align,
  output logic                             grant_align,
  input  logic [3:0]                       be_bulk,
  // client data
  input  logic [31:0]                      data_w,
  output logic [31:0]                      data_r,
  output logic                             read_valid,
  // sdram pins
  output ddr_pkg::ddr_cmd_e                cmd,
  output logic [ddr_pkg::ddr_addr_w-1:0]   ddr_addr,
  output logic [ddr_pkg::bank_w-1:0]       ddr_bank,
  output logic [15:0]                      dq_out,
  output logic                             dq_oe,
  output logic [1:0]                       dm,
  input  logic [15:0]                      dq_in
);

  logic       refresh_strobe;
  logic [3:0] cmd_be;

  refresh_timer #(.refresh_interval(refresh_interval)) u_refresh (
    .CLK(CLK), .RST(RST), .refresh_strobe(refresh_strobe)
  );

  cmd_scheduler u_sched (
    .CLK(CLK), .RST(RST), .refresh_strobe(refresh_strobe),
    .addr_rand(addr_rand), .we_rand(we_rand), .req_rand(req_rand),
    .grant_rand(grant_rand), .be_rand(be_rand),
    .addr_bulk(addr_bulk), .we_bulk(we_bulk), .req_bulk(req_bulk),
    .grant_bulk(grant_bulk), .req_align(req_align), .grant_align(grant_align),
    .be_bulk(be_bulk),
    .cmd(cmd), .ddr_addr(ddr_addr), .ddr_bank(ddr_bank), .cmd_be(cmd_be)
  );

  data_path #(.cas_latency(cas_latency)) u_data (
    .CLK(CLK), .RST(RST), .cmd(cmd), .cmd_be(cmd_be),
    .data_w(data_w), .dq_out(dq_out), .dq_oe(dq_oe), .dm(dm),
    .dq_in(dq_in), .data_r(data_r), .read_valid(read_valid)
  );

endmodule

//--- hdl/data_path.sv
module data_path #(
  parameter int cas_latency = 2
) (
  input  logic              CLK,
  input  logic              RST,
  input  ddr_pkg::ddr_cmd_e cmd,
  input  logic [3:0]        cmd_be,
  // write side
  input  logic [31:0]       data_w,
  output logic [15:0]       dq_out,
  output logic              dq_oe,
  output logic [1:0]        dm,
  // read side
  input  logic [15:0]       dq_in,
  output logic [31:0]       data_r,
  output logic              read_valid
);

  logic [1:0]           wr_sh;  // low beat, high beat
  logic [cas_latency:0] rd_sh;  // read command age in cycles
  logic [31:0]          wdata;
  logic [3:0]           wbe;
  logic [15:0]          rd_lo;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      wr_sh      <= 2'b00;
      rd_sh      <= '0;
      read_valid <= 1'b0;
    end
    else
    begin
      wr_sh      <= {wr_sh[0], cmd == ddr_pkg::wrte};
      rd_sh      <= {rd_sh[cas_latency-1:0], cmd == ddr_pkg::read};
      read_valid <= rd_sh[cas_latency];  // with the second beat in data_r
    end
  end

  // write word and byte enables held through both beats
  always_ff @(posedge CLK)
  begin
    if (cmd == ddr_pkg::wrte)
    begin
      wdata <= data_w;
      wbe   <= cmd_be;
    end
  end

  // read beats, low half first
  always_ff @(posedge CLK)
  begin
    if (rd_sh[cas_latency-1])
      rd_lo <= dq_in;
    if (rd_sh[cas_latency])
      data_r <= {dq_in, rd_lo};
  end

  assign dq_oe  = |wr_sh;
  assign dq_out = wr_sh[1] ? wdata[31:16] : wdata[15:0];
  assign dm     = wr_sh[1] ? ~wbe[3:2] : ~wbe[1:0];  // mask = disabled byte

endmodule

//--- hdl/cmd_scheduler.sv
module cmd_scheduler (
  input  logic                             CLK,
  input  logic                             RST,
  input  logic                             refresh_strobe,
  // random port
  input  logic [ddr_pkg::addr_w-1:0]       addr_rand,
  input  logic                             we_rand,
  input  logic                             req_rand,
  output logic                             grant_rand,
  input  logic [3:0]                       be_rand,
  // bulk port
  input  logic [ddr_pkg::addr_w-1:0]       addr_bulk,
  input  logic                             we_bulk,
  input  logic                             req_bulk,
  output logic                             grant_bulk,
  input  logic                             req_align,
  output logic                             grant_align,
  input  logic [3:0]                       be_bulk,
  // sdram side
  output ddr_pkg::ddr_cmd_e                cmd,
  output logic [ddr_pkg::ddr_addr_w-1:0]   ddr_addr,
  output logic [ddr_pkg::bank_w-1:0]       ddr_bank,
  output logic [3:0]                       cmd_be
);

  ddr_pkg::ddr_cmd_e               cmd_nx;
  ddr_pkg::ddr_cmd_e               last_cmd;
  logic                            second_stroke;
  logic                            page_open;
  logic                            refresh_ack;
  logic                            pend_rand;
  logic                            pend_bulk;
  logic [3:0]                      counter;
  logic [ddr_pkg::row_w-1:0]       open_row;
  logic [ddr_pkg::bank_w-1:0]      open_bank;

  logic                            use_bulk;
  logic                            want_rw;
  logic                            want_page;
  logic                            refresh_pend;
  logic                            tgt_we;
  logic [3:0]                      tgt_be;
  logic [ddr_pkg::addr_w-1:0]      tgt_addr;
  logic [ddr_pkg::row_w-1:0]       tgt_row;
  logic [ddr_pkg::bank_w-1:0]      tgt_bank;
  logic                            page_hit;
  logic                            bulk_hit;
  logic                            same_dir;
  logic                            ready_norm;
  logic                            ready_dlay;
  logic                            prch_ok;
  logic                            rw_nx;
  logic                            go;
  logic                            issue;

  // align on the bulk port steers the page towards the bulk row
  assign use_bulk  = req_bulk | req_align;
  assign tgt_addr  = use_bulk ? addr_bulk : addr_rand;
  assign tgt_we    = req_bulk ? we_bulk : we_rand;
  assign tgt_be    = req_bulk ? be_bulk : be_rand;
  assign want_rw   = req_bulk | (req_rand & ~req_align);  // random waits behind align
  assign want_page = want_rw | req_align;

  assign tgt_row  = tgt_addr[ddr_pkg::addr_w-1 -: ddr_pkg::row_w];
  assign tgt_bank = tgt_addr[ddr_pkg::col_w +: ddr_pkg::bank_w];
  assign page_hit = page_open && (tgt_row == open_row) && (tgt_bank == open_bank);
  assign bulk_hit = page_open &&
                    (addr_bulk[ddr_pkg::addr_w-1 -: ddr_pkg::row_w] == open_row) &&
                    (addr_bulk[ddr_pkg::col_w +: ddr_pkg::bank_w] == open_bank);

  assign refresh_pend = refresh_ack ^ refresh_strobe;

  // same direction on an open page skips the wait counter
  assign same_dir   = ((last_cmd == ddr_pkg::wrte) && tgt_we) ||
                      ((last_cmd == ddr_pkg::read) && !tgt_we);
  assign ready_norm = (counter <= ddr_pkg::wait_idle);
  assign ready_dlay = (counter == 4'd0);
  assign prch_ok    = (last_cmd == ddr_pkg::wrte) ? ready_dlay : ready_norm;  // write recovery

  always_comb
  begin
    cmd_nx = ddr_pkg::noop;
    go     = 1'b0;
    if (refresh_pend)
    begin
      if (page_open)
      begin
        cmd_nx = ddr_pkg::prch;  // close before refresh
        go     = prch_ok;
      end
      else
      begin
        cmd_nx = ddr_pkg::arsr;
        go     = ready_norm;
      end
    end
    else if (want_rw && page_hit)
    begin
      cmd_nx = tgt_we ? ddr_pkg::wrte : ddr_pkg::read;
      go     = same_dir || ready_norm;
    end
    else if (want_page && page_open && !page_hit)
    begin
      cmd_nx = ddr_pkg::prch;  // page miss
      go     = prch_ok;
    end
    else if (want_page && !page_open)
    begin
      cmd_nx = ddr_pkg::actv;
      go     = ready_norm;
    end
  end

  assign issue = second_stroke && go;  // never two commands back to back
  assign rw_nx = (cmd_nx == ddr_pkg::read) || (cmd_nx == ddr_pkg::wrte);

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      cmd           <= ddr_pkg::noop;
      last_cmd      <= ddr_pkg::noop;
      ddr_addr      <= ddr_pkg::all_banks_addr;
      second_stroke <= 1'b1;
      page_open     <= 1'b0;
      refresh_ack   <= 1'b0;
      counter       <= 4'd0;
      pend_rand     <= 1'b0;
      pend_bulk     <= 1'b0;
      grant_rand    <= 1'b0;
      grant_bulk    <= 1'b0;
      grant_align   <= 1'b0;
    end
    else
    begin
      second_stroke <= ~issue;
      pend_bulk     <= issue && rw_nx && req_bulk;
      pend_rand     <= issue && rw_nx && !req_bulk;
      grant_bulk    <= pend_bulk;  // one cycle behind the command
      grant_rand    <= pend_rand;
      grant_align   <= req_align && bulk_hit && !refresh_pend;
      if (issue)
      begin
        cmd      <= cmd_nx;
        last_cmd <= cmd_nx;
        counter  <= (cmd_nx == ddr_pkg::arsr) ? ddr_pkg::wait_refresh : ddr_pkg::wait_default;
        case (cmd_nx)
          ddr_pkg::actv:
          begin
            ddr_addr  <= {tgt_row[11:10], 1'b0, tgt_row[9:0]};  // a10 kept low
            page_open <= 1'b1;
          end
          ddr_pkg::read, ddr_pkg::wrte:
            ddr_addr <= {tgt_addr[ddr_pkg::col_w-1:0], 1'b0};  // first beat of the word
          ddr_pkg::prch:
          begin
            ddr_addr  <= ddr_pkg::all_banks_addr;
            page_open <= 1'b0;
          end
          ddr_pkg::arsr:
          begin
            ddr_addr    <= ddr_pkg::all_banks_addr;
            refresh_ack <= refresh_strobe;
          end
          default: ;
        endcase
      end
      else
      begin
        cmd <= ddr_pkg::noop;
        if (counter != 4'd0)
          counter <= counter - 1'b1;
      end
    end
  end

  // page and byte enable payload
  always_ff @(posedge CLK)
  begin
    if (issue && (cmd_nx == ddr_pkg::actv))
    begin
      open_row  <= tgt_row;
      open_bank <= tgt_bank;
    end
    if (issue && (cmd_nx != ddr_pkg::prch) && (cmd_nx != ddr_pkg::arsr))
      ddr_bank <= tgt_bank;
    if (issue && rw_nx)
      cmd_be <= tgt_be;
  end

endmodule

//--- hdl/refresh_timer.sv
module refresh_timer #(
  parameter int refresh_interval = 200
) (
  input  logic CLK,
  input  logic RST,
  output logic refresh_strobe
);

  logic [$clog2(refresh_interval)-1:0] cnt;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      cnt            <= '0;
      refresh_strobe <= 1'b0;
    end
    else if (cnt == refresh_interval - 1)
    begin
      cnt            <= '0;
      refresh_strobe <= ~refresh_strobe;  // one toggle per interval
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- hdl/ddr_pkg.sv
package ddr_pkg;

  // SDRAM command pins {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    noop = 3'b111,  // no operation
    actv = 3'b011,  // open a row
    read = 3'b101,
    wrte = 3'b100,
    prch = 3'b010,  // close the open row
    arsr = 3'b001   // auto refresh
  } ddr_cmd_e;

  // client address layout {row, bank, column}
  localparam int row_w  = 12;
  localparam int bank_w = 2;
  localparam int col_w  = 12;
  localparam int addr_w = row_w + bank_w + col_w;  // 26

  localparam int ddr_addr_w = 13;  // address pins

  // a10 set selects all banks on precharge
  localparam logic [ddr_addr_w-1:0] all_banks_addr = 13'h0400;

  // wait counter reloads for a countdown to zero
  localparam logic [3:0] wait_refresh = 4'd12;  // after arsr
  localparam logic [3:0] wait_default = 4'd4;   // after actv, prch, read, wrte

  // counter level that lets a change go
  localparam logic [3:0] wait_idle = 4'd2;

endpackage
